// File: sources.f
hdl/move_list_pkg.sv
hdl/host_regs.sv
hdl/move_unpacker.sv
hdl/move_list_store.sv
hdl/move_gen_ctrl.sv
testbench/lmg_model.sv
testbench/tb_move_gen_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build tb_move_gen_ctrl with verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_move_gen_ctrl -f sources.f -o sim_move_gen_ctrl &&
./obj_dir/sim_move_gen_ctrl | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/tb_move_gen_ctrl.sv
`timescale 1ns/100ps

module tb_move_gen_ctrl;
	import move_list_pkg::*;

	localparam int ram_addr_w     = 10;
	localparam int ram_words      = 2 ** ram_addr_w;
	localparam int seed_init      = 32'haf1c4a64;
	localparam int timeout_cycles = 5000;
	localparam int scratch_lo     = 40;         // host scratch words, a long list can run over the lowest

	logic                   clk;
	logic                   rst_n;
	logic [ram_addr_w-1:0]  address;
	logic                   read;
	logic                   write;
	data_t                  writedata;
	data_t                  readdata;
	board_t                 board_state;
	logic                   lmg_start;
	logic                   lmg_done;
	logic                   fifo_rd;
	fifo_word_t             fifo_data;
	logic                   fifo_empty;
	int                     exp_count;          // from the generator model
	data_t                  exp_list [32];

	int     seed;
	data_t  reg_shadow [reg_count];             // what the host wrote to each register
	data_t  ram_shadow [ram_words];
	bit     ram_known [ram_words];              // word holds a host value that must survive
	data_t  rd_value;
	board_t board_exp;
	int     addr;

	move_gen_ctrl #(.ram_addr_w(ram_addr_w)) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.address     (address),
		.read        (read),
		.write       (write),
		.writedata   (writedata),
		.readdata    (readdata),
		.board_state (board_state),
		.lmg_start   (lmg_start),
		.lmg_done    (lmg_done),
		.fifo_rd     (fifo_rd),
		.fifo_data   (fifo_data),
		.fifo_empty  (fifo_empty)
	);

	lmg_model #(.seed_init(seed_init)) u_lmg (
		.clk        (clk),
		.lmg_start  (lmg_start),
		.fifo_rd    (fifo_rd),
		.lmg_done   (lmg_done),
		.fifo_data  (fifo_data),
		.fifo_empty (fifo_empty),
		.exp_count  (exp_count),
		.exp_list   (exp_list)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==========================================================================
	// error handling and compares
	// ==========================================================================
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_board(input string name, input board_t got, input board_t exp);
		if (got !== exp)
			stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	// no pop once the generator fifo has run dry, both settled mid cycle
	always @(negedge clk) begin
		if (rst_n && fifo_empty)
			check_bit("fifo_rd", fifo_rd, 1'b0);
	end

	// ==========================================================================
	// bus access, inputs move 1 ns after the edge
	// ==========================================================================
	task automatic write_word(input int a, input data_t data);
		@(posedge clk);
		#1;
		address   = ram_addr_w'(a);
		writedata = data;
		write     = 1'b1;
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	task automatic read_word(input int a, output data_t data);
		@(posedge clk);
		#1;
		address = ram_addr_w'(a);
		read    = 1'b1;
		@(posedge clk);
		#1;
		read = 1'b0;
		data = readdata;                            // registered at the edge just passed
	endtask

	// poll the control register, two cycles per read
	task automatic wait_for_done();
		data_t ctrl;
		int    cycles;
		ctrl   = '0;
		cycles = 0;
		while (!ctrl[done_bit]) begin
			if (cycles >= timeout_cycles)
				stop_with_error("timeout, the done bit did not come up within 5000 cycles");
			read_word(ctrl_addr, ctrl);
			cycles += 2;
		end
	endtask

	// start bit write, lmg_start must follow for exactly two cycles
	task automatic start_run();
		@(posedge clk);
		#1;
		address   = ram_addr_w'(ctrl_addr);
		writedata = data_t'(1) << start_bit;
		write     = 1'b1;
		check_bit("lmg_start", lmg_start, 1'b0);
		@(posedge clk);
		#1;
		write = 1'b0;
		check_bit("lmg_start", lmg_start, 1'b1);
		@(posedge clk);
		#1;
		check_bit("lmg_start", lmg_start, 1'b1);
		@(posedge clk);
		#1;
		check_bit("lmg_start", lmg_start, 1'b0);
	endtask

	task automatic run_and_verify();
		data_t value;
		int    term_addr;
		start_run();
		wait_for_done();
		read_word(ctrl_addr, value);
		check_data("readdata (control)", value, data_t'(3));    // start and done
		read_word(count_addr, value);
		check_data("readdata (move count)", value, data_t'(exp_count));
		for (int i = 0; i < exp_count; i++) begin
			read_word(list_base + i, value);
			check_data($sformatf("readdata (move %0d)", i), value, exp_list[i]);
		end
		term_addr = list_base + exp_count;
		read_word(term_addr, value);
		check_data("readdata (terminator)", value, '0);
		for (int a = term_addr + 1; a < ram_words; a++) begin
			if (ram_known[a]) begin
				read_word(a, value);
				check_data($sformatf("readdata (ram %0d)", a), value, ram_shadow[a]);
			end
		end
		for (int a = count_addr; a <= term_addr; a++)
			ram_known[a] = 1'b0;                    // list area now holds unpacker data
		// done drops together with start
		write_word(ctrl_addr, '0);
		read_word(ctrl_addr, value);
		check_data("readdata (control)", value, '0);
	endtask

	// ==========================================================================
	// test sequence
	// ==========================================================================
	initial begin
		seed      = seed_init;
		rst_n     = 1'b0;
		address   = '0;
		read      = 1'b0;
		write     = 1'b0;
		writedata = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		read_word(ctrl_addr, rd_value);
		check_data("readdata (control)", rd_value, '0);   // control comes out of reset clear

		// registers 1..15 hold what was written
		for (int r = 1; r < reg_count; r++) begin
			reg_shadow[r] = $random(seed);
			write_word(r, reg_shadow[r]);
		end
		for (int r = 1; r < reg_count; r++) begin
			read_word(r, rd_value);
			check_data($sformatf("readdata (reg %0d)", r), rd_value, reg_shadow[r]);
		end

		// board words, reg 2 lands in the low bits
		for (int r = 0; r < 8; r++) begin
			reg_shadow[board_base + r] = $random(seed);
			write_word(board_base + r, reg_shadow[board_base + r]);
			board_exp[r*data_w +: data_w] = reg_shadow[board_base + r];
		end
		check_board("board_state", board_state, board_exp);

		// scratch ram above the list area
		for (int i = 0; i < 32; i++) begin
			addr = scratch_lo + int'($unsigned($random(seed)) % (ram_words - scratch_lo));
			ram_shadow[addr] = $random(seed);
			ram_known[addr]  = 1'b1;
			write_word(addr, ram_shadow[addr]);
		end
		for (int a = scratch_lo; a < ram_words; a++) begin
			if (ram_known[a]) begin
				read_word(a, rd_value);
				check_data($sformatf("readdata (ram %0d)", a), rd_value, ram_shadow[a]);
			end
		end

		// one run plus three more, each with a fresh list
		for (int run = 0; run < 4; run++)
			run_and_verify();

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: testbench/lmg_model.sv
`timescale 1ns/100ps

module lmg_model #(
	parameter int seed_init = 1
) (
	input  logic                        clk,
	input  logic                        lmg_start,
	input  logic                        fifo_rd,
	output logic                        lmg_done,
	output move_list_pkg::fifo_word_t   fifo_data,
	output logic                        fifo_empty,
	output int                          exp_count,      // moves the controller must list
	output move_list_pkg::data_t        exp_list [32]   // expected ram words from list_base on
);
	import move_list_pkg::*;

	int         seed;
	fifo_word_t words [4];      // at most four fifo words per run
	int         n_words;
	int         rd_ptr;         // next word to hand out
	int         delay;          // cycles left until lmg_done
	logic       start_s;        // lmg_start seen mid cycle
	logic       start_q;
	logic       rd_s;           // fifo_rd seen mid cycle

	// random word, bit 18 of each slot is random so about half the slots are invalid
	task automatic make_word(output fifo_word_t w);
		logic [slot_w-1:0] s;
		for (int k = 0; k < slots_per_word; k++) begin
			s = slot_w'($random(seed));
			w[k*slot_w +: slot_w] = s;
			if (!s[18]) begin
				// tag on top, then each square as col over row
				exp_list[exp_count] = {14'b0, s[17:12], s[8:6], s[11:9], s[2:0], s[5:3]};
				exp_count++;
			end
		end
	endtask

	initial begin
		seed       = seed_init;
		lmg_done   = 1'b0;
		fifo_data  = '0;
		fifo_empty = 1'b1;
		exp_count  = 0;
		n_words    = 0;
		rd_ptr     = 0;
		delay      = 0;
		start_q    = 1'b0;
		for (int i = 0; i < 32; i++)
			exp_list[i] = '0;
		forever begin
			@(negedge clk);
			start_s = lmg_start;                    // outputs are settled mid cycle
			rd_s    = fifo_rd;
			@(posedge clk);
			#1;
			if (start_s && !start_q) begin
				lmg_done   = 1'b0;                  // new board, fill the fifo again
				exp_count  = 0;
				n_words    = 1 + int'($unsigned($random(seed)) % 4);
				delay      = 3 + int'($unsigned($random(seed)) % 8);
				rd_ptr     = 0;
				fifo_empty = 1'b0;
				for (int i = 0; i < n_words; i++)
					make_word(words[i]);
			end else if (delay > 0) begin
				delay--;
				if (delay == 0)
					lmg_done = 1'b1;                // stays up until the next start
			end
			if (rd_s) begin
				if (rd_ptr < n_words)
					fifo_data = words[rd_ptr];      // held until the next pop
				rd_ptr++;
				fifo_empty = (rd_ptr >= n_words);
			end
			start_q = start_s;
		end
	end

endmodule

// File: hdl/move_gen_ctrl.sv
`timescale 1ns/100ps

module move_gen_ctrl #(
	parameter int ram_addr_w = 15                     // 2**ram_addr_w words of ram
) (
	input  logic                        clk,
	input  logic                        rst_n,

	// ==========================================================================
	// avalon-mm slave
	// ==========================================================================
	input  logic [ram_addr_w-1:0]       address,      // word address
	input  logic                        read,
	input  logic                        write,
	input  move_list_pkg::data_t        writedata,
	output move_list_pkg::data_t        readdata,     // one cycle after read

	// ==========================================================================
	// legal move generator
	// ==========================================================================
	output move_list_pkg::board_t       board_state,
	output logic                        lmg_start,
	input  logic                        lmg_done,
	output logic                        fifo_rd,
	input  move_list_pkg::fifo_word_t   fifo_data,
	input  logic                        fifo_empty
);
	import move_list_pkg::*;

	data_t                  reg_rdata;     // register read value toward the read mux
	logic                   run_start;     // host_regs -> unpacker
	logic                   run_done;      // unpacker -> host_regs
	logic                   unp_wr;
	logic [ram_addr_w-1:0]  unp_addr;
	data_t                  unp_wdata;

	// control, board and spare registers
	host_regs #(.ram_addr_w(ram_addr_w)) u_host_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.address     (address),
		.read        (read),
		.write       (write),
		.writedata   (writedata),
		.run_done    (run_done),
		.reg_rdata   (reg_rdata),
		.run_start   (run_start),
		.lmg_start   (lmg_start),
		.board_state (board_state)
	);

	// fifo words in, list writes out
	move_unpacker #(.ram_addr_w(ram_addr_w)) u_move_unpacker (
		.clk        (clk),
		.rst_n      (rst_n),
		.run_start  (run_start),
		.lmg_done   (lmg_done),
		.fifo_empty (fifo_empty),
		.fifo_data  (fifo_data),
		.fifo_rd    (fifo_rd),
		.unp_wr     (unp_wr),
		.unp_addr   (unp_addr),
		.unp_wdata  (unp_wdata),
		.run_done   (run_done)
	);

	// ram plus the bus read mux
	move_list_store #(.ram_addr_w(ram_addr_w)) u_move_list_store (
		.clk       (clk),
		.address   (address),
		.read      (read),
		.write     (write),
		.writedata (writedata),
		.unp_wr    (unp_wr),
		.unp_addr  (unp_addr),
		.unp_wdata (unp_wdata),
		.reg_rdata (reg_rdata),
		.readdata  (readdata)
	);

endmodule

// File: hdl/move_list_store.sv
`timescale 1ns/100ps

module move_list_store #(
	parameter int ram_addr_w = 15
) (
	input  logic                    clk,

	// host side of the bus
	input  logic [ram_addr_w-1:0]   address,
	input  logic                    read,
	input  logic                    write,
	input  move_list_pkg::data_t    writedata,

	// list writes from the unpacker
	input  logic                    unp_wr,
	input  logic [ram_addr_w-1:0]   unp_addr,
	input  move_list_pkg::data_t    unp_wdata,

	input  move_list_pkg::data_t    reg_rdata,    // already registered in host_regs
	output move_list_pkg::data_t    readdata
);
	import move_list_pkg::*;

	localparam int ram_depth = 2 ** ram_addr_w;

	// ==========================================================================
	// block ram, one write port and one read port
	// ==========================================================================
	data_t                  mem [ram_depth];
	data_t                  ram_q;        // registered ram read
	logic                   sel_reg_q;    // last read went to the register window
	logic                   is_reg;
	logic                   host_wr;
	logic                   wr_en;
	logic [ram_addr_w-1:0]  wr_addr;
	data_t                  wr_data;

	assign is_reg  = address < ram_addr_w'(reg_count);
	assign host_wr = write && !is_reg;       // words 0..15 never reach ram

	// unpacker owns the port, a colliding host write is lost
	always_comb begin
		wr_en   = unp_wr | host_wr;
		wr_addr = address;
		wr_data = writedata;
		if (unp_wr) begin
			wr_addr = unp_addr;
			wr_data = unp_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read side, one cycle latency like the register file
	always_ff @(posedge clk) begin
		if (read) begin
			ram_q     <= mem[address];           // old data on a same address write
			sel_reg_q <= is_reg;
		end
	end

	assign readdata = sel_reg_q ? reg_rdata : ram_q;

endmodule

// File: hdl/move_unpacker.sv
`timescale 1ns/100ps

module move_unpacker #(
	parameter int ram_addr_w = 15
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        run_start,    // clears count, arms for lmg_done
	input  logic                        lmg_done,
	input  logic                        fifo_empty,   // looked at on the last slot only
	input  move_list_pkg::fifo_word_t   fifo_data,    // valid the cycle after fifo_rd
	output logic                        fifo_rd,
	output logic                        unp_wr,
	output logic [ram_addr_w-1:0]       unp_addr,
	output move_list_pkg::data_t        unp_wdata,
	output logic                        run_done
);
	import move_list_pkg::*;

	localparam int idx_w = $clog2(slots_per_word);

	// ==========================================================================
	// state
	// ==========================================================================
	unpack_state_t          state;
	logic [idx_w-1:0]       slot_idx;     // slot under work in the current word
	count_t                 count;        // valid moves written so far
	logic                   armed;        // run_start seen, waiting for lmg_done
	logic                   lmg_done_q;   // for the rising edge of lmg_done
	logic                   done_rise;
	logic                   last_slot;

	slot_t                  cur_slot;
	move_t                  cur_move;
	logic [ram_addr_w-1:0]  list_addr;    // next free list word, also the terminator spot

	assign done_rise = armed && lmg_done && !lmg_done_q;
	assign last_slot = slot_idx == idx_w'(slots_per_word - 1);

	// pick one slot from the held fifo word
	assign cur_slot = slot_t'(fifo_data[slot_w*slot_idx +: slot_w]);

	// swap row and col of both squares, tag stays on top
	always_comb begin
		cur_move.tag     = cur_slot.tag;
		cur_move.dst_col = cur_slot.dst_col;
		cur_move.dst_row = cur_slot.dst_row;
		cur_move.src_col = cur_slot.src_col;
		cur_move.src_row = cur_slot.src_row;
	end

	assign list_addr = ram_addr_w'(list_base) + ram_addr_w'(count);

	assign fifo_rd = (state == pop);  // one cycle per word

	// ==========================================================================
	// fsm
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= idle;
			slot_idx   <= '0;
			count      <= '0;
			armed      <= 1'b0;
			lmg_done_q <= 1'b0;
			unp_wr     <= 1'b0;
			run_done   <= 1'b0;
		end else begin
			lmg_done_q <= lmg_done;
			unp_wr     <= 1'b0;                      // writes are single cycle strobes
			run_done   <= 1'b0;

			case (state)
				idle: begin
					if (run_start) begin
						count <= '0;                 // new run, list starts over
						armed <= 1'b1;
					end else if (done_rise) begin
						armed <= 1'b0;
						state <= pop;                // first word as soon as lmg is done
					end
				end

				pop: begin
					state <= wait_data;              // fifo answers next cycle
				end

				wait_data: begin
					slot_idx <= '0;
					state    <= slot;
				end

				slot: begin
					if (!cur_slot.invalid) begin
						unp_wr    <= 1'b1;
						unp_addr  <= list_addr;
						unp_wdata <= {{(data_w - $bits(move_t)){1'b0}}, cur_move};
						count     <= count + 1'b1;
					end
					slot_idx <= slot_idx + 1'b1;   // wraps to 0 after the eighth slot
					if (last_slot)
						state <= fifo_empty ? write_count : pop;
				end

				write_count: begin
					unp_wr    <= 1'b1;
					unp_addr  <= ram_addr_w'(count_addr);
					unp_wdata <= {{(data_w - $bits(count_t)){1'b0}}, count};
					state     <= write_end;
				end

				write_end: begin
					unp_wr    <= 1'b1;                 // zero word closes the list
					unp_addr  <= list_addr;
					unp_wdata <= '0;
					run_done  <= 1'b1;                 // lands with the terminator write
					state     <= idle;
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

// File: hdl/host_regs.sv
`timescale 1ns/100ps

module host_regs #(
	parameter int ram_addr_w = 15
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [ram_addr_w-1:0]   address,
	input  logic                    read,
	input  logic                    write,
	input  move_list_pkg::data_t    writedata,
	input  logic                    run_done,     // one cycle, list is complete
	output move_list_pkg::data_t    reg_rdata,    // registered, valid the cycle after read
	output logic                    run_start,    // one cycle, tells the unpacker to arm
	output logic                    lmg_start,    // two cycles to the generator
	output move_list_pkg::board_t   board_state
);
	import move_list_pkg::*;

	localparam int board_regs = $bits(board_t) / data_w;   // eight words of board

	// ==========================================================================
	// decode
	// ==========================================================================
	data_t    regs [reg_count];    // regs[ctrl_addr] is the control word
	data_t    ctrl_next;
	reg_idx_t reg_idx;
	logic     is_reg;              // address falls in the register window
	logic     reg_wr;
	logic     ctrl_wr;
	logic     start_rise;          // start goes 0 -> 1 on this write
	logic [1:0] start_pipe;        // shift of start_rise, gives the 2 cycle lmg_start

	assign is_reg  = address < ram_addr_w'(reg_count);
	assign reg_idx = address[$bits(reg_idx_t)-1:0];
	assign reg_wr  = write && is_reg;
	assign ctrl_wr = reg_wr && (reg_idx == reg_idx_t'(ctrl_addr));

	assign start_rise = ctrl_wr && writedata[start_bit] && !regs[ctrl_addr][start_bit];

	// next control word
	always_comb begin
		ctrl_next = regs[ctrl_addr];
		if (ctrl_wr) begin
			ctrl_next           = writedata;
			ctrl_next[done_bit] = regs[ctrl_addr][done_bit];  // host cannot set done itself
		end
		if (run_done)
			ctrl_next[done_bit] = 1'b1;                   // unpacker finished the list
		if (!ctrl_next[start_bit])
			ctrl_next[done_bit] = 1'b0;                   // done never stands without start
	end

	// ==========================================================================
	// register file
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs[ctrl_addr] <= '0;
			start_pipe      <= '0;
		end else begin
			regs[ctrl_addr] <= ctrl_next;
			if (reg_wr && !ctrl_wr)
				regs[reg_idx] <= writedata;              // plain data regs, board and spares
			start_pipe <= {start_pipe[0], start_rise};
		end
	end

	// lmg_start from the edge after the write, for two cycles
	assign lmg_start = start_pipe[0] | start_pipe[1];
	assign run_start = start_pipe[0];                     // unpacker arms with the first one

	// read port, the store muxes this against ram data
	always_ff @(posedge clk) begin
		if (read && is_reg)
			reg_rdata <= regs[reg_idx];
	end

	// board words straight out to the generator
	always_comb begin
		for (int k = 0; k < board_regs; k++) begin
			board_state[k*data_w +: data_w] = regs[board_base + k];
		end
	end

endmodule

// File: hdl/move_list_pkg.sv
package move_list_pkg;

	// ==========================================================================
	// bus and register file
	// ==========================================================================
	localparam int data_w = 32;             // avalon word width, same as ram word
	typedef logic [data_w-1:0] data_t;

	localparam int reg_count = 16;          // interface regs live at 0..15
	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

	typedef logic [255:0] board_t;          // reg 2 is the low word, reg 9 the top word

	// address map
	localparam int ctrl_addr  = 0;          // control register
	localparam int board_base = 2;          // first of eight board words
	localparam int count_addr = 16;         // ram word with the move count
	localparam int list_base  = 17;         // first move of the list

	// control register bits
	localparam int start_bit = 0;
	localparam int done_bit  = 1;

	// ==========================================================================
	// lmg fifo words and moves
	// ==========================================================================
	localparam int slots_per_word = 8;
	localparam int slot_w         = 19;
	typedef logic [slots_per_word*slot_w-1:0] fifo_word_t;  // slot k at bits 19k+18:19k

	// one slot as the generator packs it, msb first
	typedef struct packed {
		logic       invalid;                // 0 means the slot holds a move
		logic [5:0] tag;
		logic [2:0] dst_row;
		logic [2:0] dst_col;
		logic [2:0] src_row;
		logic [2:0] src_col;
	} slot_t;

	// move as the host sees it, row and column of each square swapped
	typedef struct packed {
		logic [5:0] tag;
		logic [2:0] dst_col;
		logic [2:0] dst_row;
		logic [2:0] src_col;
		logic [2:0] src_row;
	} move_t;

	typedef logic [7:0] count_t;            // moves written in one run

	typedef enum logic [2:0] {idle, pop, wait_data, slot, write_count, write_end} unpack_state_t;

endpackage
